//--- verilog.f
verilog/trap_pkg.sv
verilog/int_ctrl.sv
verilog/exc_ctrl.sv
verilog/trap_csr.sv
verilog/trap_unit.sv
test/tb_trap_unit.sv

//--- Makefile
# Verilator build and run of the trap unit testbench

.PHONY: sim clean

sim:
	verilator --binary --timing -f verilog.f --top-module tb_trap_unit --Mdir obj_dir
	out=$$(./obj_dir/Vtb_trap_unit); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir

//--- test/tb_trap_unit.sv
/*
 trap unit testbench
 directed tests for CSR access, exceptions, timer interrupt and mret
*/

`timescale 1ns/1ps

module tb_trap_unit import trap_pkg::*; ();

	localparam int CLK_PERIOD   = 4;
	localparam int RESET_CYCLES = 5;
	// watchdog covers the per-test cycle budgets plus a margin
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 60 + 40 + 50 + 60 + 40 + 100;
	localparam logic [XLEN-1:0] MIE_MASK = (1 << MIE_BIT_MEI) | (1 << MIE_BIT_MTI);
	localparam logic [XLEN-1:0] MSTATUS_MASK = (1 << MSTATUS_MIE_BIT) | (1 << MSTATUS_MPIE_BIT);
	localparam logic [XLEN-1:0] INSTR_ECALL = 32'h00000073;
	localparam logic [XLEN-1:0] INSTR_MRET  = 32'h30200073;
	localparam logic [XLEN-1:0] INSTR_NOP   = 32'h00000013;	// addi x0, x0, 0
	localparam logic [XLEN-1:0] INSTR_JAL   = 32'h0000006f;

	logic                  cpu_clk;
	logic                  rst_n;
	logic                  kplic_int, core_timer_int;
	logic                  instr_valid, jump_valid;
	logic [XLEN-1:0]       instr, pc, jump_target;
	csr_op_e               csr_op;
	logic [CSR_ADDR_W-1:0] csr_addr;
	logic [XLEN-1:0]       csr_write_data;
	logic [XLEN-1:0]       csr_read_data, vector_addr, epc;
	logic                  trap, mret_taken;

	trap_unit dut0 (.*);

	initial begin
		cpu_clk = 1'b0;
		forever #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("CHECKS FAILED");
		$fatal(1);
	end

	task automatic check_data(input string name, input logic [XLEN-1:0] got,
			input logic [XLEN-1:0] exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	// write, set and clear rules of a CSR access
	function automatic logic [XLEN-1:0] model_csr_op(input csr_op_e op,
			input logic [XLEN-1:0] cur, input logic [XLEN-1:0] wdata);
		if (op == csr_write)
			return wdata;
		else if (op == csr_set)
			return cur | wdata;
		else if (op == csr_clear)
			return cur & ~wdata;
		return cur;
	endfunction

	task automatic csr_access(input csr_op_e op, input logic [CSR_ADDR_W-1:0] addr,
			input logic [XLEN-1:0] wdata);
		@(posedge cpu_clk);
		csr_op         <= op;
		csr_addr       <= addr;
		csr_write_data <= wdata;
		@(posedge cpu_clk);
		csr_op <= csr_none;	// write lands at this edge
	endtask

	task automatic csr_read(input logic [CSR_ADDR_W-1:0] addr, output logic [XLEN-1:0] data);
		@(posedge cpu_clk);
		csr_addr <= addr;
		@(negedge cpu_clk);
		data = csr_read_data;
	endtask

	task automatic check_cause(input logic exp_int, input trap_cause_e exp_code);
		logic [XLEN-1:0] rdata;
		logic [XLEN-1:0] exp;
		exp = XLEN'(exp_code);
		exp[XLEN-1] = exp_int;	// interrupt flag in the top bit
		csr_read(CSR_MCAUSE, rdata);
		if (rdata !== exp) begin
			$display("Mismatch mcause: got %h expected %h", rdata, exp);
			$display("CHECKS FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_csr(input logic [CSR_ADDR_W-1:0] addr, input string name,
			input logic [XLEN-1:0] exp);
		logic [XLEN-1:0] rdata;
		csr_read(addr, rdata);
		check_data(name, rdata, exp);
	endtask

	// drives one slot and returns at the negedge after the taking edge
	task automatic run_slot(input logic [XLEN-1:0] word, input logic [XLEN-1:0] slot_pc,
			input logic jmp, input logic [XLEN-1:0] target);
		@(posedge cpu_clk);
		instr_valid <= 1'b1;
		instr       <= word;
		pc          <= slot_pc;
		jump_valid  <= jmp;
		jump_target <= target;
		@(posedge cpu_clk);
		instr_valid <= 1'b0;
		jump_valid  <= 1'b0;
		@(negedge cpu_clk);
	endtask

	task automatic expect_trap(input logic [XLEN-1:0] exp_vec);
		check_bit("trap", trap, 1'b1);
		check_bit("mret_taken", mret_taken, 1'b0);
		check_data("vector_addr", vector_addr, exp_vec);
		@(negedge cpu_clk);
		check_bit("trap", trap, 1'b0);	// single pulse
	endtask

	task automatic check_csr_ops(input logic [CSR_ADDR_W-1:0] addr, input string name,
			input logic [XLEN-1:0] mask);
		logic [XLEN-1:0] model;
		logic [XLEN-1:0] wdata;
		csr_op_e         op;
		model = '0;	// all CSRs clear after reset
		check_csr(addr, name, model);
		for (int i = 0; i < 3; i++) begin
			case (i)
				0:       op = csr_write;
				1:       op = csr_set;
				default: op = csr_clear;
			endcase
			wdata = $urandom;
			csr_access(op, addr, wdata);
			model = model_csr_op(op, model, wdata) & mask;
			check_csr(addr, name, model);
		end
	endtask

	task automatic test_csr_access();
		check_csr_ops(CSR_MTVEC, "mtvec", '1);
		check_csr_ops(CSR_MIE, "mie", MIE_MASK);
		check_csr_ops(CSR_MSTATUS, "mstatus", MSTATUS_MASK);
		csr_access(csr_write, CSR_MIE, '0);
		csr_access(csr_write, CSR_MSTATUS, '0);
	endtask

	task automatic test_ecall_direct(output logic [XLEN-1:0] slot_pc);
		logic [XLEN-1:0] base;
		base    = $urandom & ~32'h3;	// mode bits zero for direct
		slot_pc = $urandom & ~32'h3;
		csr_access(csr_write, CSR_MTVEC, base);
		csr_access(csr_write, CSR_MSTATUS, 1 << MSTATUS_MIE_BIT);
		run_slot(INSTR_ECALL, slot_pc, 1'b0, '0);
		expect_trap(base);
		check_csr(CSR_MEPC, "mepc", slot_pc);
		check_cause(1'b0, cause_ecall_m);
		check_csr(CSR_MTVAL, "mtval", '0);
		check_csr(CSR_MSTATUS, "mstatus", 1 << MSTATUS_MPIE_BIT);
	endtask

	task automatic test_illegal_and_jump();
		logic [XLEN-1:0] base, word, target;
		base   = $urandom & ~32'h3;
		word   = $urandom | 32'h7f;	// opcode 7'h7f is not RV32I
		target = ($urandom & ~32'h3) | 32'h2;
		csr_access(csr_write, CSR_MTVEC, base);
		run_slot(word, $urandom & ~32'h3, 1'b0, '0);
		expect_trap(base);
		check_cause(1'b0, cause_illegal);
		check_csr(CSR_MTVAL, "mtval", word);
		run_slot(INSTR_JAL, $urandom & ~32'h3, 1'b1, target);
		expect_trap(base);
		check_cause(1'b0, cause_instr_misaligned);
		check_csr(CSR_MTVAL, "mtval", target);
		run_slot(word, $urandom & ~32'h3, 1'b1, target);	// illegal beats bad jump
		expect_trap(base);
		check_cause(1'b0, cause_illegal);
		check_csr(CSR_MTVAL, "mtval", word);
	endtask

	task automatic test_timer_vectored();
		logic [XLEN-1:0] base, slot_pc;
		base    = $urandom & ~32'h3;
		slot_pc = $urandom & ~32'h3;
		csr_access(csr_write, CSR_MTVEC, base | 32'h1);
		csr_access(csr_set, CSR_MIE, 1 << MIE_BIT_MTI);
		csr_access(csr_write, CSR_MSTATUS, 1 << MSTATUS_MIE_BIT);
		@(posedge cpu_clk);
		core_timer_int <= 1'b1;
		@(posedge cpu_clk);	// mip samples the line here
		run_slot(INSTR_NOP, slot_pc, 1'b0, '0);
		expect_trap(base + 32'd28);
		check_cause(1'b1, cause_m_timer);
		check_csr(CSR_MEPC, "mepc", slot_pc);
		check_csr(CSR_MTVAL, "mtval", '0);
		// same stimulus with mtie clear
		@(posedge cpu_clk);
		core_timer_int <= 1'b0;
		csr_access(csr_clear, CSR_MIE, 1 << MIE_BIT_MTI);
		csr_access(csr_write, CSR_MSTATUS, 1 << MSTATUS_MIE_BIT);
		@(posedge cpu_clk);
		core_timer_int <= 1'b1;
		@(posedge cpu_clk);
		run_slot(INSTR_NOP, $urandom & ~32'h3, 1'b0, '0);
		check_bit("trap", trap, 1'b0);
		check_csr(CSR_MIP, "mip", 1 << MIE_BIT_MTI);
		@(posedge cpu_clk);
		core_timer_int <= 1'b0;
		csr_access(csr_write, CSR_MSTATUS, '0);
	endtask

	task automatic test_mret();
		logic [XLEN-1:0] trap_pc;
		test_ecall_direct(trap_pc);	// leaves MPIE set and MIE clear
		run_slot(INSTR_MRET, $urandom & ~32'h3, 1'b0, '0);
		check_bit("mret_taken", mret_taken, 1'b1);
		check_bit("trap", trap, 1'b0);
		check_data("epc", epc, trap_pc);
		@(negedge cpu_clk);
		check_bit("mret_taken", mret_taken, 1'b0);
		check_csr(CSR_MSTATUS, "mstatus", MSTATUS_MASK);
	endtask

	initial begin
		logic [XLEN-1:0] unused_pc;
		void'($urandom(11564));
		rst_n          = 1'b0;
		kplic_int      = 1'b0;
		core_timer_int = 1'b0;
		instr_valid    = 1'b0;
		instr          = '0;
		pc             = '0;
		jump_valid     = 1'b0;
		jump_target    = '0;
		csr_op         = csr_none;
		csr_addr       = '0;
		csr_write_data = '0;
		repeat (RESET_CYCLES) @(posedge cpu_clk);
		rst_n <= 1'b1;
		@(negedge cpu_clk);
		check_bit("trap", trap, 1'b0);
		check_bit("mret_taken", mret_taken, 1'b0);
		test_csr_access();
		test_ecall_direct(unused_pc);
		test_illegal_and_jump();
		test_timer_vectored();
		test_mret();
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- verilog/trap_unit.sv
/*
 machine mode trap unit
 interrupt control, exception decode and trap CSRs of a small RV32 core
*/

`timescale 1ns/1ps

module trap_unit import trap_pkg::*; (
	input  logic                  cpu_clk,
	input  logic                  rst_n,
	input  logic                  kplic_int,
	input  logic                  core_timer_int,
	input  logic                  instr_valid,	// one instruction per cycle
	input  logic [XLEN-1:0]       instr,
	input  logic [XLEN-1:0]       pc,
	input  logic                  jump_valid,
	input  logic [XLEN-1:0]       jump_target,
	input  csr_op_e               csr_op,
	input  logic [CSR_ADDR_W-1:0] csr_addr,
	input  logic [XLEN-1:0]       csr_write_data,
	output logic [XLEN-1:0]       csr_read_data,
	output logic                  trap,
	output logic [XLEN-1:0]       vector_addr,
	output logic                  mret_taken,
	output logic [XLEN-1:0]       epc
);

	logic            int_req;
	trap_cause_e     int_cause;
	logic [XLEN-1:0] int_read_data;
	logic            mstatus_mie;
	logic            exc_valid;
	trap_cause_e     exc_cause;
	logic [XLEN-1:0] exc_tval;
	logic            mret_req;

	int_ctrl u_int_ctrl (
		.cpu_clk        (cpu_clk),
		.rst_n          (rst_n),
		.kplic_int      (kplic_int),
		.core_timer_int (core_timer_int),
		.mstatus_mie    (mstatus_mie),
		.csr_op         (csr_op),
		.csr_addr       (csr_addr),
		.csr_write_data (csr_write_data),
		.int_req        (int_req),
		.int_cause      (int_cause),
		.int_read_data  (int_read_data)
	);

	exc_ctrl u_exc_ctrl (
		.instr_valid (instr_valid),
		.instr       (instr),
		.pc          (pc),
		.jump_valid  (jump_valid),
		.jump_target (jump_target),
		.exc_valid   (exc_valid),
		.exc_cause   (exc_cause),
		.exc_tval    (exc_tval),
		.mret_req    (mret_req)
	);

	trap_csr u_trap_csr (
		.cpu_clk        (cpu_clk),
		.rst_n          (rst_n),
		.instr_valid    (instr_valid),
		.pc             (pc),
		.int_req        (int_req),
		.int_cause      (int_cause),
		.exc_valid      (exc_valid),
		.exc_cause      (exc_cause),
		.exc_tval       (exc_tval),
		.mret_req       (mret_req),
		.csr_op         (csr_op),
		.csr_addr       (csr_addr),
		.csr_write_data (csr_write_data),
		.int_read_data  (int_read_data),
		.mstatus_mie    (mstatus_mie),
		.csr_read_data  (csr_read_data),
		.trap           (trap),
		.vector_addr    (vector_addr),
		.mret_taken     (mret_taken),
		.epc            (epc)
	);

endmodule

//--- verilog/trap_csr.sv
/*
 trap CSR block
 picks interrupt or exception, captures mepc, mcause and mtval,
 computes the vector address, handles mret and serves the trap CSRs
*/

`timescale 1ns/1ps

module trap_csr import trap_pkg::*; (
	input  logic                  cpu_clk,
	input  logic                  rst_n,
	input  logic                  instr_valid,
	input  logic [XLEN-1:0]       pc,
	input  logic                  int_req,
	input  trap_cause_e           int_cause,
	input  logic                  exc_valid,
	input  trap_cause_e           exc_cause,
	input  logic [XLEN-1:0]       exc_tval,
	input  logic                  mret_req,
	input  csr_op_e               csr_op,
	input  logic [CSR_ADDR_W-1:0] csr_addr,
	input  logic [XLEN-1:0]       csr_write_data,
	input  logic [XLEN-1:0]       int_read_data,	// mie and mip from int_ctrl
	output logic                  mstatus_mie,
	output logic [XLEN-1:0]       csr_read_data,
	output logic                  trap,
	output logic [XLEN-1:0]       vector_addr,
	output logic                  mret_taken,
	output logic [XLEN-1:0]       epc
);

	logic            mstatus_mpie;
	logic [XLEN-1:0] mtvec;
	logic [XLEN-1:0] mepc;
	logic            mcause_int;
	trap_cause_e     mcause_code;
	logic [XLEN-1:0] mtval;

	logic            take_int, take_trap, take_mret;
	logic            csr_acc;
	logic [XLEN-1:0] mstatus_val, mcause_val;
	logic [XLEN-1:0] mstatus_new, mcause_new;
	logic [XLEN-1:0] mtvec_base;
	tvec_mode_e      mtvec_mode;
	logic [XLEN-1:0] vector_next;
	logic [XLEN-1:0] csr_local;

	// an interrupt preempts whatever the slot would have done
	assign take_int  = instr_valid & int_req;
	assign take_trap = take_int | exc_valid;
	assign take_mret = mret_req & ~take_trap;
	assign csr_acc   = (csr_op != csr_none);

	always_comb begin
		mstatus_val = '0;
		mstatus_val[MSTATUS_MIE_BIT]  = mstatus_mie;
		mstatus_val[MSTATUS_MPIE_BIT] = mstatus_mpie;
	end

	assign mcause_val  = {mcause_int, {(XLEN-6){1'b0}}, mcause_code};
	assign mstatus_new = csr_update(csr_op, mstatus_val, csr_write_data);
	assign mcause_new  = csr_update(csr_op, mcause_val, csr_write_data);
	assign mtvec_base  = {mtvec[XLEN-1:2], 2'b00};
	assign mtvec_mode  = tvec_mode_e'(mtvec[1:0]);	// modes 2 and 3 act as direct

	always_comb begin
		if (take_int && mtvec_mode == tvec_vectored)
			vector_next = mtvec_base + {{(XLEN-7){1'b0}}, int_cause, 2'b00};
		else
			vector_next = mtvec_base;
	end

	// trap and mret entry win over a CSR write to mstatus
	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			mstatus_mie  <= 1'b0;
			mstatus_mpie <= 1'b0;
		end else if (take_trap) begin
			mstatus_mpie <= mstatus_mie;
			mstatus_mie  <= 1'b0;
		end else if (take_mret) begin
			mstatus_mie  <= mstatus_mpie;
			mstatus_mpie <= 1'b1;
		end else if (csr_acc && csr_addr == CSR_MSTATUS) begin
			mstatus_mie  <= mstatus_new[MSTATUS_MIE_BIT];
			mstatus_mpie <= mstatus_new[MSTATUS_MPIE_BIT];
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (!rst_n)
			mtvec <= '0;
		else if (csr_acc && csr_addr == CSR_MTVEC)
			mtvec <= csr_update(csr_op, mtvec, csr_write_data);
	end

	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			mepc        <= '0;
			mcause_int  <= 1'b0;
			mcause_code <= cause_instr_misaligned;
			mtval       <= '0;
		end else begin
			if (csr_acc && csr_addr == CSR_MEPC)
				mepc <= csr_update(csr_op, mepc, csr_write_data) & ~32'h3;
			if (csr_acc && csr_addr == CSR_MCAUSE) begin
				mcause_int  <= mcause_new[XLEN-1];
				mcause_code <= trap_cause_e'(mcause_new[4:0]);
			end
			if (csr_acc && csr_addr == CSR_MTVAL)
				mtval <= csr_update(csr_op, mtval, csr_write_data);
			if (take_trap) begin	// capture overrides a same-cycle write
				mepc        <= pc;
				mcause_int  <= take_int;
				mcause_code <= take_int ? int_cause : exc_cause;
				mtval       <= take_int ? '0 : exc_tval;
			end
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			trap       <= 1'b0;
			mret_taken <= 1'b0;
		end else begin
			trap       <= take_trap;
			mret_taken <= take_mret;
		end
	end

	always_ff @(posedge cpu_clk) begin
		if (take_trap)
			vector_addr <= vector_next;
	end

	assign epc = mepc;

	always_comb begin
		case (csr_addr)
			CSR_MSTATUS: csr_local = mstatus_val;
			CSR_MTVEC:   csr_local = mtvec;
			CSR_MEPC:    csr_local = mepc;
			CSR_MCAUSE:  csr_local = mcause_val;
			CSR_MTVAL:   csr_local = mtval;
			default:     csr_local = '0;
		endcase
	end

	assign csr_read_data = csr_local | int_read_data;

endmodule

//--- verilog/exc_ctrl.sv
/*
 exception decode
 checks the instruction in the current slot and flags illegal
 instructions, ebreak, ecall, misaligned targets and mret
*/

`timescale 1ns/1ps

module exc_ctrl import trap_pkg::*; (
	input  logic            instr_valid,
	input  logic [XLEN-1:0] instr,
	input  logic [XLEN-1:0] pc,
	input  logic            jump_valid,	// slot redirects to jump_target
	input  logic [XLEN-1:0] jump_target,
	output logic            exc_valid,
	output trap_cause_e     exc_cause,
	output logic [XLEN-1:0] exc_tval,
	output logic            mret_req
);

	opcode_e     opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	logic [11:0] funct12;
	logic        rd_rs1_zero;
	logic        legal, is_ecall, is_ebreak, is_mret;
	logic        jmp_misaligned, pc_misaligned;

	assign opcode      = opcode_e'(instr[6:0]);
	assign funct3      = instr[14:12];
	assign funct7      = instr[31:25];
	assign funct12     = instr[31:20];
	assign rd_rs1_zero = (instr[11:7] == 5'd0) && (instr[19:15] == 5'd0);

	always_comb begin
		legal     = 1'b1;
		is_ecall  = 1'b0;
		is_ebreak = 1'b0;
		is_mret   = 1'b0;
		case (opcode)
			OPC_LUI, OPC_AUIPC, OPC_JAL, OPC_MISC_MEM: legal = 1'b1;
			OPC_JALR:   legal = (funct3 == 3'b000);
			OPC_BRANCH: legal = (funct3 != 3'b010) && (funct3 != 3'b011);
			OPC_LOAD:   legal = funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
			OPC_STORE:  legal = funct3 inside {3'b000, 3'b001, 3'b010};
			OPC_OP_IMM: begin	// shift-immediates carry a funct7
				if (funct3 == 3'b001)
					legal = (funct7 == 7'h00);
				else if (funct3 == 3'b101)
					legal = funct7 inside {7'h00, 7'h20};
			end
			OPC_OP: legal = (funct7 == 7'h00) ||
				((funct7 == 7'h20) && (funct3 inside {3'b000, 3'b101}));
			OPC_SYSTEM: begin
				if (funct3 == 3'b000 && rd_rs1_zero) begin
					case (funct12)
						FUNCT12_ECALL:  is_ecall  = 1'b1;
						FUNCT12_EBREAK: is_ebreak = 1'b1;
						FUNCT12_MRET:   is_mret   = 1'b1;
						default:        legal     = 1'b0;	// wfi is not supported
					endcase
				end else begin
					legal = (funct3 != 3'b000) && (funct3 != 3'b100);	// csr ops
				end
			end
			default: legal = 1'b0;
		endcase
	end

	assign jmp_misaligned = jump_valid && (jump_target[1:0] != 2'b00);
	assign pc_misaligned  = (pc[1:0] != 2'b00);

	// priority: illegal, ebreak, ecall, jump target, then the slot's own pc
	always_comb begin
		exc_cause = cause_instr_misaligned;
		exc_tval  = '0;
		if (!legal) begin
			exc_cause = cause_illegal;
			exc_tval  = instr;
		end else if (is_ebreak) begin
			exc_cause = cause_breakpoint;
		end else if (is_ecall) begin
			exc_cause = cause_ecall_m;
		end else if (jmp_misaligned) begin
			exc_tval = jump_target;
		end else if (pc_misaligned) begin
			exc_tval = pc;
		end
	end

	assign exc_valid = instr_valid &
		(~legal | is_ebreak | is_ecall | jmp_misaligned | pc_misaligned);
	assign mret_req  = instr_valid & legal & is_mret & ~jmp_misaligned & ~pc_misaligned;

endmodule

//--- verilog/int_ctrl.sv
/*
 interrupt control
 samples the external and timer interrupt lines into mip, holds the
 mie enables and raises the interrupt request for the trap logic
*/

`timescale 1ns/1ps

module int_ctrl import trap_pkg::*; (
	input  logic                  cpu_clk,
	input  logic                  rst_n,
	input  logic                  kplic_int,	// platform interrupt level
	input  logic                  core_timer_int,
	input  logic                  mstatus_mie,	// global enable
	input  csr_op_e               csr_op,
	input  logic [CSR_ADDR_W-1:0] csr_addr,
	input  logic [XLEN-1:0]       csr_write_data,
	output logic                  int_req,
	output trap_cause_e           int_cause,
	output logic [XLEN-1:0]       int_read_data
);

	logic            meip, mtip;
	logic            meie, mtie;
	logic [XLEN-1:0] mie_val;
	logic [XLEN-1:0] mip_val;
	logic [XLEN-1:0] mie_new;
	logic            ext_hit, tmr_hit;

	// pending bits just follow the lines, one cycle late
	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			meip <= 1'b0;
			mtip <= 1'b0;
		end else begin
			meip <= kplic_int;
			mtip <= core_timer_int;
		end
	end

	assign mie_new = csr_update(csr_op, mie_val, csr_write_data);

	always_ff @(posedge cpu_clk) begin
		if (!rst_n) begin
			meie <= 1'b0;
			mtie <= 1'b0;
		end else if (csr_op != csr_none && csr_addr == CSR_MIE) begin
			meie <= mie_new[MIE_BIT_MEI];
			mtie <= mie_new[MIE_BIT_MTI];
		end
	end

	always_comb begin
		mie_val = '0;
		mie_val[MIE_BIT_MEI] = meie;
		mie_val[MIE_BIT_MTI] = mtie;
		mip_val = '0;
		mip_val[MIE_BIT_MEI] = meip;
		mip_val[MIE_BIT_MTI] = mtip;
	end

	always_comb begin
		case (csr_addr)
			CSR_MIE: int_read_data = mie_val;
			CSR_MIP: int_read_data = mip_val;	// read only
			default: int_read_data = '0;
		endcase
	end

	assign ext_hit   = meip & meie;
	assign tmr_hit   = mtip & mtie;
	assign int_req   = mstatus_mie & (ext_hit | tmr_hit);
	assign int_cause = ext_hit ? cause_m_ext : cause_m_timer;	// external first

endmodule

//--- verilog/trap_pkg.sv
/*
 trap unit package
 widths, machine CSR addresses, cause codes and the enums shared by
 the interrupt, exception and trap CSR blocks
*/

package trap_pkg;

	localparam int XLEN       = 32;
	localparam int CSR_ADDR_W = 12;

	// machine CSR addresses
	localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
	localparam logic [CSR_ADDR_W-1:0] CSR_MIE     = 12'h304;
	localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
	localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
	localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;
	localparam logic [CSR_ADDR_W-1:0] CSR_MTVAL   = 12'h343;
	localparam logic [CSR_ADDR_W-1:0] CSR_MIP     = 12'h344;

	localparam int MIE_BIT_MEI      = 11;	// same position in mip
	localparam int MIE_BIT_MTI      = 7;
	localparam int MSTATUS_MIE_BIT  = 3;
	localparam int MSTATUS_MPIE_BIT = 7;

	// RV32I major opcodes, anything else is illegal
	typedef enum logic [6:0] {
		OPC_LUI      = 7'b0110111,
		OPC_AUIPC    = 7'b0010111,
		OPC_JAL      = 7'b1101111,
		OPC_JALR     = 7'b1100111,
		OPC_BRANCH   = 7'b1100011,
		OPC_LOAD     = 7'b0000011,
		OPC_STORE    = 7'b0100011,
		OPC_OP_IMM   = 7'b0010011,
		OPC_OP       = 7'b0110011,
		OPC_MISC_MEM = 7'b0001111,
		OPC_SYSTEM   = 7'b1110011
	} opcode_e;

	localparam logic [11:0] FUNCT12_ECALL  = 12'h000;
	localparam logic [11:0] FUNCT12_EBREAK = 12'h001;
	localparam logic [11:0] FUNCT12_MRET   = 12'h302;

	typedef enum logic [1:0] {csr_none, csr_write, csr_set, csr_clear} csr_op_e;

	// exception codes; interrupt flag is kept apart
	typedef enum logic [4:0] {
		cause_instr_misaligned = 5'd0,
		cause_illegal          = 5'd2,
		cause_breakpoint       = 5'd3,
		cause_m_timer          = 5'd7,
		cause_ecall_m          = 5'd11
	} trap_cause_e;

	// machine external interrupt shares code 11 with ecall
	localparam trap_cause_e cause_m_ext = cause_ecall_m;

	typedef enum logic [1:0] {tvec_direct = 2'd0, tvec_vectored = 2'd1} tvec_mode_e;

	// new CSR value for a write, set or clear access
	function automatic logic [XLEN-1:0] csr_update(input csr_op_e op,
			input logic [XLEN-1:0] cur, input logic [XLEN-1:0] wdata);
		case (op)
			csr_write: return wdata;
			csr_set:   return cur | wdata;
			csr_clear: return cur & ~wdata;
			default:   return cur;
		endcase
	endfunction

endpackage
